//--- tb.f
+incdir+verif
hdl/ahb_sub_pkg.sv
hdl/ahb_decode.sv
hdl/reg_execute.sv
hdl/resp_result.sv
hdl/ahb_sub.sv
verif/ahb_sub_tb.sv

//--- verif/ahb_sub_model.svh
`ifndef AHB_SUB_MODEL_SVH
`define AHB_SUB_MODEL_SVH

// Reference state, advanced once per rising edge
burst_kind_e       m_kind;
int                m_beats;         // SEQ beats left in a fixed burst
logic              m_wr;
logic              m_rd;
logic              m_bad;
logic [ADDR_W-1:0] m_addr;
logic [DATA_W-1:0] m_wdata;
logic [DATA_W-1:0] m_wr_data;
logic [DATA_W-1:0] m_bias;
logic [7:0]        m_ctrl;
logic [7:0]        m_act;
logic              m_is_weight;
logic              m_push;
logic              m_hshake;
int                m_err_st;        // 0 idle, 1 first, 2 second, 3 last

function automatic logic [1:0] required_size(input logic [ADDR_W-1:0] a);
    if (a <= DWORD_SPAN_END) return SIZE_DWORD;
    return (a < ADDR_CTRL) ? SIZE_HALF : SIZE_BYTE;
endfunction

function automatic logic addr_unmapped();
    if (m_wr) begin
        case (m_addr)
            ADDR_WEIGHT, ADDR_INPUT, ADDR_BIAS, ADDR_CTRL, ADDR_ACT: return 1'b0;
            default: return 1'b1;
        endcase
    end
    if (m_rd) begin
        case (m_addr)
            ADDR_BIAS, ADDR_OUTPUT, ADDR_ERR, ADDR_CTRL, ADDR_STATUS, ADDR_ACT: return 1'b0;
            default: return 1'b1;
        endcase
    end
    return 1'b0;
endfunction

function automatic logic [DATA_W-1:0] read_word();
    if (!m_rd) return '0;
    case (m_addr)
        ADDR_BIAS:   return m_bias;
        ADDR_OUTPUT: return output_data;
        ADDR_ERR:    return DATA_W'(err_reg) << 24;
        ADDR_CTRL:   return DATA_W'(m_ctrl) << 40;
        ADDR_STATUS: return DATA_W'(status_reg) << 48;
        ADDR_ACT:    return DATA_W'(m_act);
        default:     return '0;
    endcase
endfunction

task automatic reset_model();
    {m_wr, m_rd, m_bad, m_is_weight, m_push, m_hshake} = '0;
    m_kind    = BK_IDLE;
    m_beats   = 0;
    m_addr    = '0;
    m_wdata   = '0;
    m_wr_data = '0;
    m_bias    = '0;
    m_ctrl    = '0;
    m_act     = '0;
    m_err_st  = 0;
endtask

task automatic step_model();
    logic any_err;
    logic seq_bad;
    any_err  = m_bad || addr_unmapped() || err_reg[0] || err_reg[8];
    m_hshake = m_rd && (m_addr == ADDR_OUTPUT) && status_reg[0] && !any_err;
    m_push   = m_wr && (m_addr == ADDR_WEIGHT || m_addr == ADDR_INPUT);
    if (m_push) begin
        m_wr_data   = m_wdata;
        m_is_weight = (m_addr == ADDR_WEIGHT);
    end
    if (m_wr && m_addr == ADDR_BIAS) m_bias = m_wdata;
    if (m_wr && m_addr == ADDR_CTRL) m_ctrl = m_wdata[47:40];
    if (m_wr && m_addr == ADDR_ACT) m_act = m_wdata[7:0];
    case (m_err_st)
        0:       m_err_st = any_err ? 1 : 0;
        1:       m_err_st = any_err ? 2 : 3;
        default: m_err_st = any_err ? 2 : 0;
    endcase

    // Address phase against the burst kind seen before this edge
    seq_bad = (m_kind == BK_IDLE) ? (htrans == HTRANS_SEQ)
                                  : (m_kind != BK_SINGLE && htrans == HTRANS_NONSEQ);
    m_wr  = 1'b0;
    m_rd  = 1'b0;
    m_bad = 1'b0;
    if (hsel && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ)) begin
        if (!seq_bad && haddr <= ADDR_ACT && hsize == required_size(haddr)) begin
            m_addr = haddr;
            m_wr   = hwrite;
            m_rd   = !hwrite;
            if (hwrite) m_wdata = hwdata;
        end else begin
            m_bad = 1'b1;
        end
    end

    if (!hsel || htrans == HTRANS_IDLE) begin
        m_kind = BK_IDLE;
    end else if (m_kind == BK_IDLE && htrans == HTRANS_NONSEQ) begin
        case (hburst)
            HBURST_SINGLE: m_kind = BK_SINGLE;
            HBURST_INCR:   m_kind = BK_UNDEF;
            default: begin
                m_kind  = BK_FIXED;
                m_beats = (2 << hburst[2:1]) - 1;   // Length less the NONSEQ beat
            end
        endcase
    end else if (m_kind == BK_SINGLE && htrans != HTRANS_BUSY) begin
        m_kind = BK_IDLE;
    end else if (m_kind == BK_FIXED && htrans == HTRANS_SEQ) begin
        m_beats = m_beats - 1;
        if (m_beats == 0) m_kind = BK_IDLE;
    end
endtask

`endif

//--- verif/ahb_sub_tb.sv
`timescale 1ns/1ps

module ahb_sub_tb import ahb_sub_pkg::*; ();

    localparam int RESET_CYCLES  = 3;
    localparam int DIRECTED_MAX  = 200;     // Upper bound for the directed phase
    localparam int RANDOM_CYCLES = 2000;
    localparam int MAX_CYCLES    = (RESET_CYCLES + DIRECTED_MAX + RANDOM_CYCLES) * 4 / 3;
    localparam logic [8*ADDR_W-1:0] MAP_ADDRS = {ADDR_ACT, ADDR_STATUS, ADDR_CTRL, ADDR_ERR,
                                                 ADDR_OUTPUT, ADDR_BIAS, ADDR_INPUT, ADDR_WEIGHT};

    logic              clk = 1'b0;
    logic              n_rst;
    logic              hsel;
    logic              hwrite;
    logic [1:0]        htrans;
    logic [1:0]        hsize;
    logic [2:0]        hburst;
    logic [ADDR_W-1:0] haddr;
    logic [DATA_W-1:0] hwdata;
    logic              hready;
    logic              hresp;
    logic [DATA_W-1:0] hrdata;
    logic [DATA_W-1:0] output_data;
    logic [7:0]        status_reg;
    logic [15:0]       err_reg;
    logic [DATA_W-1:0] write_data;
    logic              is_weight;
    logic              wr_en_push;
    logic [DATA_W-1:0] bias_reg;
    logic [7:0]        ctrl_reg;
    logic [2:0]        act_mode;
    logic              handshake;
    int                cycles = 0;

    `include "ahb_sub_model.svh"

    ahb_sub dut (.*);

    always #20 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("ERR %s: got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [ADDR_W-1:0] map_at(input int idx);
        return MAP_ADDRS[idx*ADDR_W +: ADDR_W];
    endfunction

    task automatic bus_cycle(input logic sel, input logic wr, input logic [1:0] trans,
                             input logic [1:0] size, input logic [2:0] burst,
                             input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        hsel   <= sel;
        hwrite <= wr;
        htrans <= trans;
        hsize  <= size;
        hburst <= burst;
        haddr  <= addr;
        hwdata <= data;
    endtask

    task automatic single_access(input logic wr, input logic [ADDR_W-1:0] addr,
                                 input logic [DATA_W-1:0] data);
        bus_cycle(1'b1, wr, HTRANS_NONSEQ, required_size(addr), HBURST_SINGLE, addr, data);
    endtask

    task automatic burst_beat(input logic [1:0] trans, input logic [2:0] burst);
        bus_cycle(1'b1, 1'b1, trans, SIZE_DWORD, burst, ADDR_WEIGHT, {$urandom, $urandom});
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) bus_cycle(1'b0, 1'b0, HTRANS_IDLE, SIZE_BYTE, HBURST_SINGLE, '0, '0);
    endtask

    task automatic random_cycle();
        logic [ADDR_W-1:0] addr;
        logic [1:0]        trans;
        int                r;
        r     = $urandom_range(0, 99);
        trans = (r < 40) ? HTRANS_NONSEQ : (r < 70) ? HTRANS_SEQ :
                (r < 85) ? HTRANS_BUSY : HTRANS_IDLE;
        addr  = ($urandom_range(0, 9) < 8) ? map_at($urandom_range(0, 7)) : ADDR_W'($urandom);
        bus_cycle($urandom_range(0, 9) != 0, $urandom_range(0, 1), trans,
                  ($urandom_range(0, 6) != 0) ? required_size(addr) : 2'($urandom),
                  3'($urandom), addr, {$urandom, $urandom});
        if ($urandom_range(0, 3) == 0) output_data <= {$urandom, $urandom};
        if ($urandom_range(0, 29) == 0) status_reg <= 8'($urandom);
        if ($urandom_range(0, 19) == 0) begin
            // Error flags set on about a quarter of updates
            err_reg <= 16'($urandom) & (($urandom_range(0, 3) == 0) ? 16'hFFFF : 16'hFEFE);
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!n_rst) reset_model();
        check_value("hready", hready, m_err_st == 0);
        check_value("hresp", hresp, m_err_st != 0);
        check_value("hrdata", hrdata, read_word());
        check_value("handshake", handshake, m_hshake);
        check_value("wr_en_push", wr_en_push, m_push);
        check_value("write_data", write_data, m_wr_data);
        check_value("is_weight", is_weight, m_is_weight);
        check_value("bias_reg", bias_reg, m_bias);
        check_value("ctrl_reg", ctrl_reg, m_ctrl);
        check_value("act_mode", act_mode, m_act[2:0]);
        if (n_rst) step_model();
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            fail_run($sformatf("Timeout, the run did not end within %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        void'($urandom(22));
        {n_rst, hsel, hwrite, htrans, hsize, hburst, haddr, hwdata} = '0;
        {output_data, status_reg, err_reg} = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        n_rst <= 1'b1;

        // Writes, then readback of every readable register
        single_access(1'b1, ADDR_WEIGHT, 64'h0123_4567_89AB_CDEF);
        single_access(1'b1, ADDR_INPUT, 64'hFEDC_BA98_7654_3210);
        single_access(1'b1, ADDR_BIAS, 64'h1111_2222_3333_4444);
        single_access(1'b1, ADDR_CTRL, 64'h0000_A500_0000_0000);
        single_access(1'b1, ADDR_ACT, 64'h0000_0000_0000_0006);
        single_access(1'b1, ADDR_WEIGHT, 64'h5555_AAAA_5555_AAAA);
        output_data <= 64'hCAFE_F00D_1234_5678;
        status_reg  <= 8'hA4;
        err_reg     <= 16'h3C5A;
        idle_cycles(2);
        for (int i = 2; i < 8; i++) single_access(1'b0, map_at(i), '0);
        idle_cycles(2);

        // Wrong size, unmapped address, write to a read-only register
        bus_cycle(1'b1, 1'b1, HTRANS_NONSEQ, SIZE_BYTE, HBURST_SINGLE, ADDR_BIAS, '1);
        idle_cycles(4);
        single_access(1'b0, 10'h030, '0);
        idle_cycles(4);
        single_access(1'b1, ADDR_ERR, '0);
        single_access(1'b1, ADDR_ERR, '0);
        idle_cycles(5);

        burst_beat(HTRANS_NONSEQ, HBURST_INCR4);    // Clean INCR4 with BUSY gaps
        burst_beat(HTRANS_BUSY, HBURST_INCR4);
        burst_beat(HTRANS_SEQ, HBURST_INCR4);
        burst_beat(HTRANS_BUSY, HBURST_INCR4);
        repeat (2) burst_beat(HTRANS_SEQ, HBURST_INCR4);
        idle_cycles(3);
        burst_beat(HTRANS_NONSEQ, HBURST_WRAP4);    // One SEQ too many
        repeat (4) burst_beat(HTRANS_SEQ, HBURST_WRAP4);
        idle_cycles(4);
        burst_beat(HTRANS_NONSEQ, HBURST_INCR8);    // NONSEQ mid burst
        burst_beat(HTRANS_SEQ, HBURST_INCR8);
        burst_beat(HTRANS_NONSEQ, HBURST_INCR8);
        idle_cycles(4);
        burst_beat(HTRANS_NONSEQ, HBURST_INCR);
        repeat (5) burst_beat(HTRANS_SEQ, HBURST_INCR);
        idle_cycles(3);

        // Handshake with data ready, without it, and during an error
        status_reg <= 8'h01;
        err_reg    <= 16'h0000;
        single_access(1'b0, ADDR_OUTPUT, '0);
        idle_cycles(3);
        status_reg <= 8'h00;
        single_access(1'b0, ADDR_OUTPUT, '0);
        idle_cycles(3);
        status_reg <= 8'h01;
        err_reg    <= 16'h0100;
        single_access(1'b0, ADDR_OUTPUT, '0);
        idle_cycles(1);
        err_reg <= 16'h0000;
        idle_cycles(5);

        err_reg <= 16'h0001;    // Accelerator flags alone
        idle_cycles(1);
        err_reg <= 16'h0000;
        idle_cycles(5);
        err_reg <= 16'h0100;
        idle_cycles(3);
        err_reg <= 16'h0000;
        idle_cycles(5);

        for (int i = 0; i < RANDOM_CYCLES; i++) random_cycle();
        idle_cycles(4);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- hdl/ahb_sub.sv
`timescale 1ns/1ps

module ahb_sub import ahb_sub_pkg::*; (
    input  logic              clk,
    input  logic              n_rst,
    // AHB-Lite
    input  logic              hsel,
    input  logic              hwrite,
    input  logic [1:0]        htrans,
    input  logic [1:0]        hsize,
    input  logic [2:0]        hburst,
    input  logic [ADDR_W-1:0] haddr,
    input  logic [DATA_W-1:0] hwdata,
    output logic              hready,
    output logic              hresp,
    output logic [DATA_W-1:0] hrdata,
    // Accelerator side
    input  logic [DATA_W-1:0] output_data,
    input  logic [7:0]        status_reg,
    input  logic [15:0]       err_reg,
    output logic [DATA_W-1:0] write_data,
    output logic              is_weight,
    output logic              wr_en_push,
    output logic [DATA_W-1:0] bias_reg,
    output logic [7:0]        ctrl_reg,
    output logic [2:0]        act_mode,
    output logic              handshake
);

    access_t  access;
    rf_word_u rf_rdata;
    logic     addr_err;
    logic     out_read;

    ahb_decode u_decode (
        .clk    (clk),
        .n_rst  (n_rst),
        .hsel   (hsel),
        .hwrite (hwrite),
        .htrans (htrans),
        .hsize  (hsize),
        .hburst (hburst),
        .haddr  (haddr),
        .hwdata (hwdata),
        .access (access)
    );

    reg_execute u_execute (
        .clk         (clk),
        .n_rst       (n_rst),
        .access      (access),
        .output_data (output_data),
        .status_reg  (status_reg),
        .err_reg     (err_reg),
        .write_data  (write_data),
        .is_weight   (is_weight),
        .wr_en_push  (wr_en_push),
        .bias_reg    (bias_reg),
        .ctrl_reg    (ctrl_reg),
        .act_mode    (act_mode),
        .rf_rdata    (rf_rdata),
        .addr_err    (addr_err),
        .out_read    (out_read)
    );

    resp_result u_result (
        .clk        (clk),
        .n_rst      (n_rst),
        .access     (access),
        .addr_err   (addr_err),
        .out_read   (out_read),
        .rf_rdata   (rf_rdata),
        .err_reg    (err_reg),
        .status_reg (status_reg),
        .hready     (hready),
        .hresp      (hresp),
        .hrdata     (hrdata),
        .handshake  (handshake)
    );

endmodule

//--- hdl/resp_result.sv
`timescale 1ns/1ps

module resp_result import ahb_sub_pkg::*; (
    input  logic              clk,
    input  logic              n_rst,
    input  access_t           access,
    input  logic              addr_err,
    input  logic              out_read,
    input  rf_word_u          rf_rdata,
    input  logic [15:0]       err_reg,
    input  logic [7:0]        status_reg,
    output logic              hready,
    output logic              hresp,
    output logic [DATA_W-1:0] hrdata,
    output logic              handshake
);

    typedef enum logic [1:0] {
        ERR_IDLE,
        ERR_FIRST,
        ERR_SECOND,
        ERR_LAST
    } err_state_e;

    err_state_e state;
    err_state_e state_n;
    logic       any_error;

    // Bus faults plus the accelerator's own error flags
    assign any_error = access.bad || addr_err || err_reg[0] || err_reg[8];

    always_comb begin
        case (state)
            ERR_IDLE:   state_n = any_error ? ERR_FIRST  : ERR_IDLE;
            ERR_FIRST:  state_n = any_error ? ERR_SECOND : ERR_LAST;
            ERR_SECOND: state_n = any_error ? ERR_SECOND : ERR_IDLE;
            ERR_LAST:   state_n = any_error ? ERR_SECOND : ERR_IDLE;
            default:    state_n = ERR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state     <= ERR_IDLE;
            handshake <= 1'b0;
        end else begin
            state <= state_n;
            // Output consumed while the accelerator has data ready
            handshake <= out_read && status_reg[0] && !any_error;
        end
    end

    assign hresp  = (state != ERR_IDLE);
    assign hready = !hresp;
    assign hrdata = rf_rdata.raw;

endmodule

//--- hdl/reg_execute.sv
`timescale 1ns/1ps

module reg_execute import ahb_sub_pkg::*; (
    input  logic              clk,
    input  logic              n_rst,
    input  access_t           access,
    input  logic [DATA_W-1:0] output_data,
    input  logic [7:0]        status_reg,
    input  logic [15:0]       err_reg,
    output logic [DATA_W-1:0] write_data,
    output logic              is_weight,
    output logic              wr_en_push,
    output logic [DATA_W-1:0] bias_reg,
    output logic [7:0]        ctrl_reg,
    output logic [2:0]        act_mode,
    output rf_word_u          rf_rdata,
    output logic              addr_err,
    output logic              out_read
);

    logic [7:0] act_reg;
    rf_word_u   rd_word;
    logic       wr_hit;
    logic       rd_hit;

    // Writable addresses
    always_comb begin
        case (access.addr)
            ADDR_WEIGHT, ADDR_INPUT, ADDR_BIAS, ADDR_CTRL, ADDR_ACT: wr_hit = 1'b1;
            default: wr_hit = 1'b0;
        endcase
    end

    // Readback word, each register in its own lane
    always_comb begin
        rd_word = '0;
        rd_hit  = 1'b1;
        case (access.addr)
            ADDR_BIAS:   rd_word.raw          = bias_reg;
            ADDR_OUTPUT: rd_word.raw          = output_data;
            ADDR_ERR:    rd_word.lanes.err    = err_reg;
            ADDR_CTRL:   rd_word.lanes.ctrl   = ctrl_reg;
            ADDR_STATUS: rd_word.lanes.status = status_reg;
            ADDR_ACT:    rd_word.lanes.act    = act_reg;
            default:     rd_hit               = 1'b0;
        endcase
    end

    assign rf_rdata = access.rd ? rd_word : '0;
    assign addr_err = (access.wr && !wr_hit) || (access.rd && !rd_hit);
    assign out_read = access.rd && (access.addr == ADDR_OUTPUT);
    assign act_mode = act_reg[2:0];

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            write_data <= '0;
            is_weight  <= 1'b0;
            wr_en_push <= 1'b0;
            bias_reg   <= '0;
            ctrl_reg   <= '0;
            act_reg    <= '0;
        end else begin
            wr_en_push <= 1'b0;     // Strobe lasts one cycle

            if (access.wr) begin
                case (access.addr)
                    ADDR_WEIGHT: begin
                        write_data <= access.wdata.raw;
                        is_weight  <= 1'b1;
                        wr_en_push <= 1'b1;
                    end
                    ADDR_INPUT: begin
                        write_data <= access.wdata.raw;
                        is_weight  <= 1'b0;
                        wr_en_push <= 1'b1;
                    end
                    ADDR_BIAS: bias_reg <= access.wdata.raw;
                    ADDR_CTRL: ctrl_reg <= access.wdata.lanes.ctrl;
                    ADDR_ACT:  act_reg  <= access.wdata.lanes.act;
                    default: ;  // Unmapped write, flagged through addr_err
                endcase
            end
        end
    end

endmodule

//--- hdl/ahb_decode.sv
`timescale 1ns/1ps

module ahb_decode import ahb_sub_pkg::*; (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              hsel,
    input  logic              hwrite,
    input  logic [1:0]        htrans,
    input  logic [1:0]        hsize,
    input  logic [2:0]        hburst,
    input  logic [ADDR_W-1:0] haddr,
    input  logic [DATA_W-1:0] hwdata,
    output access_t           access
);

    burst_kind_e       kind;
    burst_kind_e       kind_n;
    logic [BEAT_W-1:0] beats;
    logic [BEAT_W-1:0] beats_n;
    logic              trans_valid;
    logic              size_ok;
    logic              seq_err;

    assign trans_valid = hsel && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);

    always_comb begin
        if (haddr <= DWORD_SPAN_END) begin
            size_ok = (hsize == SIZE_DWORD);
        end else if (haddr >= ADDR_ERR && haddr < ADDR_CTRL) begin
            size_ok = (hsize == SIZE_HALF);
        end else if (haddr >= ADDR_CTRL && haddr <= ADDR_ACT) begin
            size_ok = (hsize == SIZE_BYTE);
        end else begin
            size_ok = 1'b0;     // Outside the register window
        end
    end

    always_comb begin
        case (kind)
            BK_IDLE:            seq_err = (htrans == HTRANS_SEQ);
            BK_UNDEF, BK_FIXED: seq_err = (htrans == HTRANS_NONSEQ);
            default:            seq_err = 1'b0;
        endcase
    end

    // Burst kind tracking
    always_comb begin
        kind_n  = kind;
        beats_n = beats;

        if (!hsel || htrans == HTRANS_IDLE) begin
            kind_n  = BK_IDLE;
            beats_n = '0;
        end else begin
            case (kind)
                BK_IDLE: begin
                    if (htrans == HTRANS_NONSEQ) begin
                        // Count holds the SEQ beats still to come
                        case (hburst)
                            HBURST_SINGLE: kind_n = BK_SINGLE;
                            HBURST_INCR:   kind_n = BK_UNDEF;
                            HBURST_WRAP4, HBURST_INCR4: begin
                                kind_n  = BK_FIXED;
                                beats_n = BEAT_W'(3);
                            end
                            HBURST_WRAP8, HBURST_INCR8: begin
                                kind_n  = BK_FIXED;
                                beats_n = BEAT_W'(7);
                            end
                            HBURST_WRAP16, HBURST_INCR16: begin
                                kind_n  = BK_FIXED;
                                beats_n = BEAT_W'(15);
                            end
                            default: kind_n = BK_IDLE;
                        endcase
                    end
                end

                BK_SINGLE: begin
                    if (htrans != HTRANS_BUSY) begin
                        kind_n = BK_IDLE;
                    end
                end

                BK_FIXED: begin
                    if (htrans == HTRANS_SEQ) begin
                        if (beats > BEAT_W'(1)) begin
                            beats_n = beats - BEAT_W'(1);
                        end else begin
                            kind_n  = BK_IDLE;  // Last beat
                            beats_n = '0;
                        end
                    end
                end

                default: kind_n = kind;     // Undefined length runs until IDLE
            endcase
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            kind   <= BK_IDLE;
            beats  <= '0;
            access <= '0;
        end else begin
            kind       <= kind_n;
            beats      <= beats_n;
            access.wr  <= 1'b0;
            access.rd  <= 1'b0;
            access.bad <= 1'b0;

            if (trans_valid) begin
                if (size_ok && !seq_err) begin
                    access.addr <= haddr;
                    access.wr   <= hwrite;
                    access.rd   <= !hwrite;
                    if (hwrite) begin
                        access.wdata.raw <= hwdata;
                    end
                end else begin
                    access.bad <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/ahb_sub_pkg.sv
package ahb_sub_pkg;

    localparam int DATA_W = 64;
    localparam int ADDR_W = 10;
    localparam int BEAT_W = 4;      // Remaining SEQ beats, max 15

    // Transfer types
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    // Burst types
    localparam logic [2:0] HBURST_SINGLE = 3'b000;
    localparam logic [2:0] HBURST_INCR   = 3'b001;
    localparam logic [2:0] HBURST_WRAP4  = 3'b010;
    localparam logic [2:0] HBURST_INCR4  = 3'b011;
    localparam logic [2:0] HBURST_WRAP8  = 3'b100;
    localparam logic [2:0] HBURST_INCR8  = 3'b101;
    localparam logic [2:0] HBURST_WRAP16 = 3'b110;
    localparam logic [2:0] HBURST_INCR16 = 3'b111;

    localparam logic [1:0] SIZE_BYTE  = 2'd0;
    localparam logic [1:0] SIZE_HALF  = 2'd1;
    localparam logic [1:0] SIZE_DWORD = 2'd3;

    // Register map
    localparam logic [ADDR_W-1:0] ADDR_WEIGHT = 10'h000;
    localparam logic [ADDR_W-1:0] ADDR_INPUT  = 10'h008;
    localparam logic [ADDR_W-1:0] ADDR_BIAS   = 10'h010;
    localparam logic [ADDR_W-1:0] ADDR_OUTPUT = 10'h018;
    localparam logic [ADDR_W-1:0] ADDR_ERR    = 10'h020;
    localparam logic [ADDR_W-1:0] ADDR_CTRL   = 10'h022;
    localparam logic [ADDR_W-1:0] ADDR_STATUS = 10'h023;
    localparam logic [ADDR_W-1:0] ADDR_ACT    = 10'h024;

    // Everything up to here is doubleword only
    localparam logic [ADDR_W-1:0] DWORD_SPAN_END = 10'h01F;

    typedef enum logic [1:0] {
        BK_IDLE,
        BK_SINGLE,
        BK_UNDEF,
        BK_FIXED
    } burst_kind_e;

    // Byte lane view of the 64-bit register word
    typedef struct packed {
        logic [7:0]  pad_hi;
        logic [7:0]  status;    // 55:48
        logic [7:0]  ctrl;      // 47:40
        logic [15:0] err;       // 39:24
        logic [15:0] pad_lo;
        logic [7:0]  act;       // 7:0
    } rf_lanes_t;

    typedef union packed {
        logic [DATA_W-1:0] raw;
        rf_lanes_t         lanes;
    } rf_word_u;

    typedef struct packed {
        logic              wr;
        logic              rd;
        logic              bad;
        logic [ADDR_W-1:0] addr;
        rf_word_u          wdata;
    } access_t;

endpackage
